/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_rv_exec
FILELIST ?= rv_exec.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* execution.sv */
`timescale 1ns/1ns

module execution (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              uop_valid,
	input  rv_exec_pkg::uop_t uop,
	output logic [4:0]        rs1_adr,
	output logic [4:0]        rs2_adr,
	input  logic [31:0]       rs1_data,
	input  logic [31:0]       rs2_data,
	output logic              ma_valid,
	output rv_exec_pkg::ma_t  ma,
	output logic              jmp_valid,
	output rv_exec_pkg::jmp_t jmp
);

logic [31:0] op2;
logic [31:0] add_res;
logic [31:0] alu_res;
logic [31:0] pc_data;
logic [31:0] pcp4;
logic [31:0] tgt_base;
logic [31:0] target;
logic [31:0] rd_data;
logic sub_en;
logic eq;
logic lt;
logic ltu;
logic br_cond;
logic taken;

// register file read through mem_wb, bypass included
assign rs1_adr = uop.rs1_adr;
assign rs2_adr = uop.rs2_adr;

// second operand, branches compare against rs2
assign op2 = (uop.cmd_alu | uop.cmd_br) ? rs2_data :
	uop.cmd_alui_shamt ? {27'd0, uop.imm[4:0]} : uop.imm;

assign sub_en = uop.cmd_alu & uop.sub;
assign add_res = sub_en ? (rs1_data - op2) : (rs1_data + op2);

// shared by slt/sltu and the branch condition
assign eq = (rs1_data == op2);
assign lt = ($signed(rs1_data) < $signed(op2));
assign ltu = (rs1_data < op2);

always_comb begin
	if (uop.cmd_ld | uop.cmd_st) begin
		// address generation
		alu_res = add_res;
	end else begin
		case (uop.alu_code)
			3'b000: alu_res = add_res;
			3'b001: alu_res = rs1_data << op2[4:0];
			3'b010: alu_res = {31'd0, lt};
			3'b011: alu_res = {31'd0, ltu};
			3'b100: alu_res = rs1_data ^ op2;
			3'b101: begin
				if (uop.sub) begin
					alu_res = $signed(rs1_data) >>> op2[4:0];
				end else begin
					alu_res = rs1_data >> op2[4:0];
				end
			end
			3'b110: alu_res = rs1_data | op2;
			default: alu_res = rs1_data & op2;
		endcase
	end
end

// target adder, separate from the alu
assign pc_data = {uop.pc, 2'b00};
assign pcp4 = pc_data + 32'd4;
assign tgt_base = uop.cmd_jalr ? rs1_data : pc_data;
assign target = tgt_base + uop.imm;

always_comb begin
	case (uop.alu_code)
		3'b000: br_cond = eq;
		3'b001: br_cond = ~eq;
		3'b100: br_cond = lt;
		3'b101: br_cond = ~lt;
		3'b110: br_cond = ltu;
		3'b111: br_cond = ~ltu;
		default: br_cond = 1'b0;
	endcase
end

assign taken = uop.cmd_jal | uop.cmd_jalr | (uop.cmd_br & br_cond);

assign rd_data = uop.cmd_lui ? uop.imm :
	(uop.cmd_jal | uop.cmd_jalr) ? pcp4 :
	uop.cmd_auipc ? target : alu_res;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		ma_valid <= 1'b0;
		jmp_valid <= 1'b0;
	end else begin
		ma_valid <= uop_valid;
		jmp_valid <= uop_valid & taken;
	end
end

always_ff @(posedge clk) begin
	if (uop_valid) begin
		ma.ld <= uop.cmd_ld;
		ma.st <= uop.cmd_st;
		ma.wbk <= uop.wbk;
		ma.rd_adr <= uop.rd_adr;
		ma.rd_data <= rd_data;
		ma.st_data <= rs2_data;
		ma.ldst_code <= uop.alu_code;
		// jalr bit 0 dropped along with bit 1
		jmp <= target[31:2];
	end
end

// the item that jumps is never a load or a store
a_jmp_with_ma: assert property (@(posedge clk) disable iff (!rst_n)
	jmp_valid |-> (ma_valid && !ma.ld && !ma.st));

endmodule

/* inst_decode.sv */
`timescale 1ns/1ns

module inst_decode (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              inst_valid,
	input  logic [31:0]       inst,
	input  logic [31:2]       pc,
	output logic              uop_valid,
	output rv_exec_pkg::uop_t uop,
	output logic              illegal
);

logic [6:0] opcode;
logic [2:0] funct3;
logic [6:0] funct7;
logic [31:0] imm_i;
logic [31:0] imm_s;
logic [31:0] imm_b;
logic [31:0] imm_u;
logic [31:0] imm_j;
rv_exec_pkg::uop_t dec;
logic legal;

assign opcode = inst[6:0];
assign funct3 = inst[14:12];
assign funct7 = inst[31:25];

// immediate formats
assign imm_i = {{20{inst[31]}}, inst[31:20]};
assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
assign imm_u = {inst[31:12], 12'd0};
assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

always_comb begin
	dec = '0;
	legal = 1'b0;
	dec.alu_code = funct3;
	dec.rs1_adr = inst[19:15];
	dec.rs2_adr = inst[24:20];
	dec.rd_adr = inst[11:7];
	dec.pc = pc;
	case (opcode)
		rv_exec_pkg::OP_LUI: begin
			legal = 1'b1;
			dec.cmd_lui = 1'b1;
			dec.wbk = 1'b1;
			dec.imm = imm_u;
		end
		rv_exec_pkg::OP_AUIPC: begin
			legal = 1'b1;
			dec.cmd_auipc = 1'b1;
			dec.wbk = 1'b1;
			dec.imm = imm_u;
		end
		rv_exec_pkg::OP_JAL: begin
			legal = 1'b1;
			dec.cmd_jal = 1'b1;
			dec.wbk = 1'b1;
			dec.imm = imm_j;
		end
		rv_exec_pkg::OP_JALR: begin
			legal = (funct3 == 3'b000);
			dec.cmd_jalr = 1'b1;
			dec.wbk = 1'b1;
			dec.imm = imm_i;
		end
		rv_exec_pkg::OP_BRANCH: begin
			// funct3 010 and 011 are unassigned
			legal = (funct3[2:1] != 2'b01);
			dec.cmd_br = 1'b1;
			dec.imm = imm_b;
		end
		rv_exec_pkg::OP_LOAD: begin
			legal = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010) ||
				(funct3 == 3'b100) || (funct3 == 3'b101);
			dec.cmd_ld = 1'b1;
			dec.wbk = 1'b1;
			dec.imm = imm_i;
		end
		rv_exec_pkg::OP_STORE: begin
			legal = (funct3[2] == 1'b0) && (funct3[1:0] != 2'b11);
			dec.cmd_st = 1'b1;
			dec.imm = imm_s;
		end
		rv_exec_pkg::OP_ALUI: begin
			dec.wbk = 1'b1;
			dec.imm = imm_i;
			if (funct3 == 3'b001) begin
				legal = (funct7 == 7'b0000000);
				dec.cmd_alui_shamt = 1'b1;
			end else if (funct3 == 3'b101) begin
				legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
				dec.cmd_alui_shamt = 1'b1;
				dec.sub = inst[30];
			end else begin
				legal = 1'b1;
				dec.cmd_alui = 1'b1;
			end
		end
		rv_exec_pkg::OP_ALU: begin
			// funct7 0100000 only for sub and sra
			legal = (funct7 == 7'b0000000) ||
				((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
			dec.cmd_alu = 1'b1;
			dec.wbk = 1'b1;
			dec.sub = inst[30];
		end
		default: begin
			legal = 1'b0;
		end
	endcase
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		uop_valid <= 1'b0;
		illegal <= 1'b0;
	end else begin
		uop_valid <= inst_valid & legal;
		illegal <= inst_valid & ~legal;
	end
end

always_ff @(posedge clk) begin
	if (inst_valid) begin
		uop <= dec;
	end
end

a_no_illegal_uop: assert property (@(posedge clk) disable iff (!rst_n)
	!(illegal && uop_valid));

endmodule

/* mem_wb.sv */
`timescale 1ns/1ns

module mem_wb #(
	parameter int DMEM_WORDS = 256
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [4:0]       rs1_adr,
	input  logic [4:0]       rs2_adr,
	output logic [31:0]      rs1_data,
	output logic [31:0]      rs2_data,
	input  logic             ma_valid,
	input  rv_exec_pkg::ma_t ma,
	output logic             wb_valid,
	output rv_exec_pkg::wb_t wb,
	output logic             st_valid,
	output rv_exec_pkg::st_t st
);

localparam int AW = $clog2(DMEM_WORDS);

logic [31:0] rf [1:31];
logic [31:0] dmem [DMEM_WORDS];
logic [AW-1:0] widx;
logic [1:0] boff;
logic [31:0] word;
logic [7:0] ld_byte;
logic [15:0] ld_half;
logic [31:0] ld_data;
logic [31:0] res;
logic [31:0] st_wdata;
logic [31:0] merged;
logic [3:0] strb;
logic fwd_en;

// word index wraps at the memory depth
assign widx = ma.rd_data[AW+1:2];
assign boff = ma.rd_data[1:0];
assign word = dmem[widx];

assign ld_byte = word[8*boff +: 8];
assign ld_half = boff[1] ? word[31:16] : word[15:0];

always_comb begin
	case (ma.ldst_code)
		3'b000: ld_data = {{24{ld_byte[7]}}, ld_byte};
		3'b001: ld_data = {{16{ld_half[15]}}, ld_half};
		3'b100: ld_data = {24'd0, ld_byte};
		3'b101: ld_data = {16'd0, ld_half};
		default: ld_data = word;
	endcase
end

// store lanes merged over the current word
always_comb begin
	case (ma.ldst_code[1:0])
		2'b00: begin
			strb = 4'b0001 << boff;
			st_wdata = {4{ma.st_data[7:0]}};
		end
		2'b01: begin
			strb = boff[1] ? 4'b1100 : 4'b0011;
			st_wdata = {2{ma.st_data[15:0]}};
		end
		default: begin
			strb = 4'b1111;
			st_wdata = ma.st_data;
		end
	endcase
	for (int i = 0; i < 4; i++) begin
		merged[8*i +: 8] = strb[i] ? st_wdata[8*i +: 8] : word[8*i +: 8];
	end
end

assign res = ma.ld ? ld_data : ma.rd_data;
assign fwd_en = ma_valid & ma.wbk & (ma.rd_adr != 5'd0);

function automatic logic [31:0] read_port(input logic [4:0] adr);
	logic [31:0] val;
	if (adr == 5'd0) begin
		val = 32'd0;
	end else if (fwd_en && (ma.rd_adr == adr)) begin
		// item retiring this cycle
		val = res;
	end else begin
		val = rf[adr];
	end
	return val;
endfunction

always_comb begin
	rs1_data = read_port(rs1_adr);
	rs2_data = read_port(rs2_adr);
end

always_ff @(posedge clk) begin
	if (fwd_en) begin
		rf[ma.rd_adr] <= res;
		wb.rd_adr <= ma.rd_adr;
		wb.rd_data <= res;
	end
	if (ma_valid && ma.st) begin
		dmem[widx] <= merged;
		st.adr <= ma.rd_data;
		st.data <= merged;
		st.strb <= strb;
	end
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		wb_valid <= 1'b0;
		st_valid <= 1'b0;
	end else begin
		wb_valid <= fwd_en;
		st_valid <= ma_valid & ma.st;
	end
end

a_load_has_wbk: assert property (@(posedge clk) disable iff (!rst_n)
	(ma_valid && ma.ld) |-> ma.wbk);

endmodule

/* rv_exec.f */
+incdir+.
rv_exec_pkg.sv
inst_decode.sv
execution.sv
mem_wb.sv
rv_exec_top.sv
tb_rv_exec.sv

/* rv_exec_pkg.sv */
package rv_exec_pkg;

	// major opcodes, bits 6:0 of the instruction word
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_ALUI   = 7'b0010011;
	localparam logic [6:0] OP_ALU    = 7'b0110011;

	// microcode bundle from decode to execution
	typedef struct packed {
		logic        cmd_lui;
		logic        cmd_auipc;
		logic        cmd_ld;
		logic        cmd_st;
		logic        cmd_alui;
		logic        cmd_alui_shamt;
		logic        cmd_alu;
		logic        cmd_jal;
		logic        cmd_jalr;
		logic        cmd_br;
		// sub for add, arithmetic for right shift
		logic        sub;
		logic [2:0]  alu_code;
		logic [4:0]  rs1_adr;
		logic [4:0]  rs2_adr;
		logic [4:0]  rd_adr;
		logic        wbk;
		// sign extended, already shaped for the format
		logic [31:0] imm;
		logic [31:2] pc;
	} uop_t;

	// execution to memory access
	typedef struct packed {
		logic        ld;
		logic        st;
		logic        wbk;
		logic [4:0]  rd_adr;
		// alu result, also the load/store byte address
		logic [31:0] rd_data;
		logic [31:0] st_data;
		logic [2:0]  ldst_code;
	} ma_t;

	typedef struct packed {
		logic [4:0]  rd_adr;
		logic [31:0] rd_data;
	} wb_t;

	typedef struct packed {
		logic [31:0] adr;
		logic [31:0] data;
		logic [3:0]  strb;
	} st_t;

	typedef logic [31:2] jmp_t;

endpackage

/* rv_exec_top.sv */
`timescale 1ns/1ns

module rv_exec_top #(
	parameter int DMEM_WORDS = 256
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              inst_valid,
	input  logic [31:0]       inst,
	input  logic [31:2]       pc,
	output logic              wb_valid,
	output rv_exec_pkg::wb_t  wb,
	output logic              st_valid,
	output rv_exec_pkg::st_t  st,
	output logic              jmp_valid,
	output rv_exec_pkg::jmp_t jmp,
	output logic              illegal
);

logic uop_valid;
rv_exec_pkg::uop_t uop;
logic [4:0] rs1_adr;
logic [4:0] rs2_adr;
logic [31:0] rs1_data;
logic [31:0] rs2_data;
logic ma_valid;
rv_exec_pkg::ma_t ma;

inst_decode i_inst_decode (
	.clk       (clk),
	.rst_n     (rst_n),
	.inst_valid(inst_valid),
	.inst      (inst),
	.pc        (pc),
	.uop_valid (uop_valid),
	.uop       (uop),
	.illegal   (illegal)
);

execution i_execution (
	.clk      (clk),
	.rst_n    (rst_n),
	.uop_valid(uop_valid),
	.uop      (uop),
	.rs1_adr  (rs1_adr),
	.rs2_adr  (rs2_adr),
	.rs1_data (rs1_data),
	.rs2_data (rs2_data),
	.ma_valid (ma_valid),
	.ma       (ma),
	.jmp_valid(jmp_valid),
	.jmp      (jmp)
);

mem_wb #(
	.DMEM_WORDS(DMEM_WORDS)
) i_mem_wb (
	.clk     (clk),
	.rst_n   (rst_n),
	.rs1_adr (rs1_adr),
	.rs2_adr (rs2_adr),
	.rs1_data(rs1_data),
	.rs2_data(rs2_data),
	.ma_valid(ma_valid),
	.ma      (ma),
	.wb_valid(wb_valid),
	.wb      (wb),
	.st_valid(st_valid),
	.st      (st)
);

endmodule

/* rv_exec_ref.svh */
`ifndef RV_EXEC_REF_SVH
`define RV_EXEC_REF_SVH

// encoders for the RV32I base formats
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, rv_exec_pkg::OP_ALU};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
	return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_exec_pkg::OP_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_exec_pkg::OP_BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
	input logic [6:0] opc);
	return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_exec_pkg::OP_JAL};
endfunction

// integer ops, alt selects sub or arithmetic right shift
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
	input logic [31:0] a, input logic [31:0] b);
	logic [31:0] r;
	case (f3)
		3'd0: r = alt ? a - b : a + b;
		3'd1: r = a << b[4:0];
		3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		3'd3: r = (a < b) ? 32'd1 : 32'd0;
		3'd4: r = a ^ b;
		3'd5: begin
			if (alt) begin
				r = $signed(a) >>> b[4:0];
			end else begin
				r = a >> b[4:0];
			end
		end
		3'd6: r = a | b;
		default: r = a & b;
	endcase
	return r;
endfunction

// runs one instruction on the model and queues what the DUT must report
function automatic void model_step(input logic [31:0] inst, input logic [31:0] pc_b);
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm_i;
	logic [31:0] res;
	logic [31:0] adr;
	logic [31:0] word;
	logic [31:0] lane_data;
	logic [3:0] strb;
	logic [2:0] f3;
	logic [4:0] rd;
	logic ok;
	logic wr;
	logic take;
	int idx;
	int i;
	f3 = inst[14:12];
	rd = inst[11:7];
	a = xreg[inst[19:15]];
	b = xreg[inst[24:20]];
	imm_i = {{20{inst[31]}}, inst[31:20]};
	ok = 1'b1;
	wr = 1'b1;
	take = 1'b0;
	res = 32'd0;
	strb = 4'd0;
	case (inst[6:0])
		rv_exec_pkg::OP_LUI: res = {inst[31:12], 12'd0};
		rv_exec_pkg::OP_AUIPC: res = pc_b + {inst[31:12], 12'd0};
		rv_exec_pkg::OP_JAL: begin
			res = pc_b + 32'd4;
			adr = pc_b + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			jmp_exp.push_back(adr[31:2]);
		end
		rv_exec_pkg::OP_JALR: begin
			ok = (f3 == 3'd0);
			res = pc_b + 32'd4;
			adr = (a + imm_i) & ~32'd1;
			if (ok) begin
				jmp_exp.push_back(adr[31:2]);
			end
		end
		rv_exec_pkg::OP_BRANCH: begin
			wr = 1'b0;
			case (f3)
				3'd0: take = (a == b);
				3'd1: take = (a != b);
				3'd4: take = ($signed(a) < $signed(b));
				3'd5: take = ($signed(a) >= $signed(b));
				3'd6: take = (a < b);
				3'd7: take = (a >= b);
				default: ok = 1'b0;
			endcase
			adr = pc_b + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			if (take) begin
				jmp_exp.push_back(adr[31:2]);
			end
		end
		rv_exec_pkg::OP_LOAD: begin
			adr = a + imm_i;
			idx = int'((adr >> 2) % DMEM_WORDS);
			word = dmem_ref[idx];
			lane_data = word >> (8 * adr[1:0]);
			case (f3)
				3'd0: res = {{24{lane_data[7]}}, lane_data[7:0]};
				3'd1: res = {{16{lane_data[15]}}, lane_data[15:0]};
				3'd2: res = word;
				3'd4: res = {24'd0, lane_data[7:0]};
				3'd5: res = {16'd0, lane_data[15:0]};
				default: ok = 1'b0;
			endcase
		end
		rv_exec_pkg::OP_STORE: begin
			wr = 1'b0;
			adr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
			idx = int'((adr >> 2) % DMEM_WORDS);
			case (f3)
				3'd0: strb = 4'b0001;
				3'd1: strb = 4'b0011;
				3'd2: strb = 4'b1111;
				default: ok = 1'b0;
			endcase
			strb = strb << adr[1:0];
			lane_data = b << (8 * adr[1:0]);
			word = dmem_ref[idx];
			for (i = 0; i < 4; i++) begin
				if (strb[i]) begin
					word[8*i +: 8] = lane_data[8*i +: 8];
				end
			end
			if (ok) begin
				dmem_ref[idx] = word;
				st_exp.push_back({adr, word, strb});
			end
		end
		rv_exec_pkg::OP_ALUI: begin
			if (f3 == 3'd1) begin
				ok = (inst[31:25] == 7'd0);
			end
			if (f3 == 3'd5) begin
				ok = (inst[31:25] == 7'd0) || (inst[31:25] == 7'h20);
			end
			res = alu_ref(f3, (f3 == 3'd5) && inst[30], a, imm_i);
		end
		rv_exec_pkg::OP_ALU: begin
			ok = (inst[31:25] == 7'd0) ||
				((inst[31:25] == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
			res = alu_ref(f3, inst[30], a, b);
		end
		default: ok = 1'b0;
	endcase
	if (!ok) begin
		ill_exp.push_back(1'b1);
	end else if (wr && (rd != 5'd0)) begin
		xreg[rd] = res;
		wb_exp.push_back({rd, res});
	end
endfunction

`endif

/* tb_rv_exec.sv */
`timescale 1ns/1ns

module tb_rv_exec;

localparam int DMEM_WORDS = 64;
localparam int N_FILL = DMEM_WORDS;
localparam int N_RAND = 400;
// three instructions per filled word, two per register x2..x7
localparam int N_INST = 3 * N_FILL + 12 + N_RAND;
localparam int MAX_CYCLES = 16 * N_INST + 200;

logic clk;
logic rst_n;
logic inst_valid;
logic [31:0] inst;
logic [31:2] pc;
logic wb_valid;
rv_exec_pkg::wb_t wb;
logic st_valid;
rv_exec_pkg::st_t st;
logic jmp_valid;
rv_exec_pkg::jmp_t jmp;
logic illegal;

// model state and expected records in program order
logic [31:0] xreg [32];
logic [31:0] dmem_ref [DMEM_WORDS];
rv_exec_pkg::wb_t wb_exp [$];
rv_exec_pkg::st_t st_exp [$];
rv_exec_pkg::jmp_t jmp_exp [$];
logic ill_exp [$];

logic [31:2] pc_next;
int cycles;
int err_wb;
int err_st;
int err_jmp;
int err_extra;

`include "rv_exec_ref.svh"

rv_exec_top #(
	.DMEM_WORDS(DMEM_WORDS)
) i_rv_exec_top (
	.clk       (clk),
	.rst_n     (rst_n),
	.inst_valid(inst_valid),
	.inst      (inst),
	.pc        (pc),
	.wb_valid  (wb_valid),
	.wb        (wb),
	.st_valid  (st_valid),
	.st        (st),
	.jmp_valid (jmp_valid),
	.jmp       (jmp),
	.illegal   (illegal)
);

initial begin
	clk = 1'b0;
	forever begin
		#5 clk = ~clk;
	end
end

task automatic send(input logic [31:0] word);
	@(posedge clk);
	#1;
	inst_valid = 1'b1;
	inst = word;
	pc = pc_next;
	model_step(word, {pc_next, 2'b00});
	pc_next = pc_next + 30'd1;
endtask

task automatic idle();
	@(posedge clk);
	#1;
	inst_valid = 1'b0;
	inst = $urandom;
endtask

// lui plus addi, leaves val in rd
task automatic load_const(input logic [4:0] rd, input logic [31:0] val);
	logic [31:0] hi;
	hi = val + 32'h800;
	send(enc_u(hi[31:12], rd, rv_exec_pkg::OP_LUI));
	send(enc_i(val[11:0], rd, 3'd0, rd, rv_exec_pkg::OP_ALUI));
endtask

// registers from x0..x7 only, so dependencies are dense
function automatic logic [31:0] random_inst();
	logic [31:0] r;
	logic [31:0] s;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [2:0] f3;
	logic [2:0] p;
	logic [11:0] ofs;
	logic [31:0] w;
	r = $urandom;
	s = $urandom;
	rd = {2'b00, r[2:0]};
	rs1 = {2'b00, r[5:3]};
	rs2 = {2'b00, r[8:6]};
	f3 = r[11:9];
	// memory offsets around x0, aligned to the access size
	ofs = {{3{s[8]}}, s[8:0]};
	case (r[31:28] % 4'd11)
		4'd1: begin
			if ((f3 == 3'd1) || (f3 == 3'd5)) begin
				ofs = {1'b0, r[12] && (f3 == 3'd5), 5'd0, s[4:0]};
			end else begin
				ofs = s[11:0];
			end
			w = enc_i(ofs, rs1, f3, rd, rv_exec_pkg::OP_ALUI);
		end
		4'd2: begin
			p = r[11:9] % 3'd5;
			f3 = (p > 3'd2) ? p + 3'd1 : p;
			ofs = ofs & ~((12'd1 << f3[1:0]) - 12'd1);
			w = enc_i(ofs, 5'd0, f3, rd, rv_exec_pkg::OP_LOAD);
		end
		4'd3: begin
			f3 = {1'b0, r[10:9] % 2'd3};
			ofs = ofs & ~((12'd1 << f3[1:0]) - 12'd1);
			w = enc_s(ofs, rs2, 5'd0, f3);
		end
		4'd4: begin
			if (f3[2:1] == 2'b01) begin
				f3[2] = 1'b1;
			end
			w = enc_b({s[12:1], 1'b0}, rs2, rs1, f3);
		end
		4'd5: w = enc_u(s[19:0], rd, rv_exec_pkg::OP_LUI);
		4'd6: w = enc_u(s[19:0], rd, rv_exec_pkg::OP_AUIPC);
		4'd7: w = enc_j({s[20:1], 1'b0}, rd);
		4'd8: w = enc_i(s[11:0], rs1, 3'd0, rd, rv_exec_pkg::OP_JALR);
		4'd10: begin
			// custom opcode, bad branch, bad load, mul
			case (r[13:12])
				2'd0: w = {s[31:7], 7'b0001011};
				2'd1: w = enc_b({s[12:1], 1'b0}, rs2, rs1, 3'd2);
				2'd2: w = enc_i(ofs, 5'd0, 3'd3, rd, rv_exec_pkg::OP_LOAD);
				default: w = enc_r(7'd1, rs2, rs1, f3, rd);
			endcase
		end
		default: w = enc_r({1'b0, r[12] && ((f3 == 3'd0) || (f3 == 3'd5)), 5'd0},
			rs2, rs1, f3, rd);
	endcase
	return w;
endfunction

task automatic compare(input string name, input logic [67:0] exp, input logic [67:0] act,
	inout int errs);
	if (exp !== act) begin
		$display("[ERROR] %s expected %h actual %h", name, exp, act);
		errs++;
	end
endtask

// outputs change on the rising edge, sampled on the falling one
always @(negedge clk) begin
	if (wb_valid) begin
		if (wb_exp.size() == 0) begin
			$display("writeback to x%0d arrived with no instruction expecting one", wb.rd_adr);
			err_extra++;
		end else begin
			compare("writeback", 68'(wb_exp.pop_front()), 68'(wb), err_wb);
		end
	end
	if (st_valid) begin
		if (st_exp.size() == 0) begin
			$display("store to %h arrived with no instruction expecting one", st.adr);
			err_extra++;
		end else begin
			compare("store", 68'(st_exp.pop_front()), 68'(st), err_st);
		end
	end
	if (jmp_valid) begin
		if (jmp_exp.size() == 0) begin
			$display("jump to %h reported while no jump was taken", {jmp, 2'b00});
			err_extra++;
		end else begin
			compare("jump", 68'(jmp_exp.pop_front()), 68'(jmp), err_jmp);
		end
	end
	if (illegal) begin
		if (ill_exp.size() == 0) begin
			$display("illegal pulse for an instruction that is legal");
			err_extra++;
		end else begin
			void'(ill_exp.pop_front());
		end
	end
end

initial begin
	cycles = 0;
	while (cycles < MAX_CYCLES) begin
		@(posedge clk);
		cycles++;
	end
	$display("timeout after %0d cycles, %0d expected records never arrived", cycles,
		wb_exp.size() + st_exp.size() + jmp_exp.size() + ill_exp.size());
	$display("Verification failed");
	$finish;
end

initial begin
	int i;
	int gap;
	void'($urandom(32'h7547_e9e9));
	rst_n = 1'b0;
	inst_valid = 1'b0;
	inst = 32'd0;
	pc = 30'd0;
	pc_next = 30'h0000_0100;
	err_wb = 0;
	err_st = 0;
	err_jmp = 0;
	err_extra = 0;
	for (i = 0; i < 32; i++) begin
		xreg[i] = 32'd0;
	end
	for (i = 0; i < DMEM_WORDS; i++) begin
		dmem_ref[i] = 32'd0;
	end
	repeat (16) @(posedge clk);
	#1;
	rst_n = 1'b1;
	// every data word gets a random value through x1
	for (i = 0; i < N_FILL; i++) begin
		load_const(5'd1, $urandom);
		send(enc_s(12'(4 * i), 5'd1, 5'd0, 3'd2));
	end
	for (i = 2; i < 8; i++) begin
		load_const(5'(i), $urandom);
	end
	for (i = 0; i < N_RAND; i++) begin
		send(random_inst());
		gap = $urandom % 4;
		if (gap == 0) begin
			repeat (1 + $urandom % 3) idle();
		end
	end
	idle();
	// drain until the pipeline has reported everything
	while (wb_exp.size() + st_exp.size() + jmp_exp.size() + ill_exp.size() != 0) begin
		idle();
	end
	repeat (4) idle();
	$display("errors: writeback %0d, store %0d, jump %0d, unexpected %0d",
		err_wb, err_st, err_jmp, err_extra);
	if (err_wb + err_st + err_jmp + err_extra == 0) begin
		$display("Verification passed");
	end else begin
		$display("Verification failed");
	end
	$finish;
end

endmodule
